// File: design/sp_pkg.sv
package sp_pkg;

    // Scratchpad word
    localparam int DATA_W = 32;
    typedef logic [DATA_W-1:0] data_t;

    localparam int BANK_ROWS = 16;
    localparam int ROW_W = $clog2(BANK_ROWS);
    typedef logic [ROW_W-1:0] row_t;

    // Fixed by the two-bit bank field of the instruction
    localparam int NUM_BANKS = 4;
    localparam int BANK_W = 2;
    typedef logic [BANK_W-1:0] bank_t;

    localparam int DRAM_ADDR_W = 16;
    typedef logic [DRAM_ADDR_W-1:0] dram_addr_t;

    // GEMM row count minus one
    localparam int CNT_W = 4;
    typedef logic [CNT_W-1:0] cnt_t;

    localparam int INSTR_W = 32;
    typedef logic [INSTR_W-1:0] instr_t;

    // Instruction field LSB positions
    localparam int OPC_W = 2;
    localparam int OPC_LSB = 30;
    localparam int BANK_LSB = 28;
    localparam int ROW_LSB = 24;
    localparam int CNT_LSB = 20;
    localparam int ADDR_LSB = 4;

    typedef enum logic [OPC_W-1:0] {
        OP_NOP = 2'd0,
        OP_LOAD = 2'd1,
        OP_STORE = 2'd2,
        OP_GEMM = 2'd3
    } opcode_e;

    typedef enum logic [3:0] {
        IDLE,
        LD_REQ,
        LD_WAIT,
        ST_READ,
        ST_REQ,
        ST_WAIT,
        GM_READ,
        GM_REQ,
        GM_WAIT
    } bank_state_e;

    // Lowest-numbered requesting bank wins
    function automatic bank_t lowest_req(input logic [NUM_BANKS-1:0] req);
        bank_t sel;
        sel = '0;
        for (int i = NUM_BANKS - 1; i >= 0; i--) begin
            if (req[i]) begin
                sel = bank_t'(i);
            end
        end
        return sel;
    endfunction

endpackage

// File: design/sync_fifo.sv
module sync_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input logic CLK,
    input logic nRST,
    input logic wen,
    input sp_pkg::instr_t wdata,
    input logic ren,
    output sp_pkg::instr_t rdata,
    output logic full,
    output logic empty
);
    import sp_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    instr_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wptr, rptr;
    logic [CNT_W-1:0] count;
    logic do_write, do_read;

    assign do_write = wen && !full;
    assign do_read = ren && !empty;

    assign full = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign rdata = mem[rptr];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wptr <= '0;
            rptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wptr <= (wptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wptr + 1'b1;
            end
            if (do_read) begin
                rptr <= (rptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage only
    always_ff @(posedge CLK) begin
        if (do_write) begin
            mem[wptr] <= wdata;
        end
    end

endmodule

// File: design/sp_bank.sv
module sp_bank (
    input logic CLK,
    input logic nRST,
    input logic wen,
    input sp_pkg::row_t waddr,
    input sp_pkg::data_t wdata,
    input logic ren,
    input sp_pkg::row_t raddr,
    output sp_pkg::data_t rdata
);
    import sp_pkg::*;

    data_t mem [BANK_ROWS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < BANK_ROWS; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else begin
            if (wen) begin
                mem[waddr] <= wdata;
            end
            // Registered read, data valid the next cycle
            if (ren) begin
                rdata <= mem[raddr];
            end
        end
    end

endmodule

// File: design/bank_access_fsm.sv
module bank_access_fsm #(
    parameter int BANK_NUM = 0
) (
    input logic CLK,
    input logic nRST,
    input sp_pkg::instr_t instr_head,
    input logic head_valid,
    output logic take,
    output logic bank_wen,
    output sp_pkg::row_t bank_waddr,
    output sp_pkg::data_t bank_wdata,
    output logic bank_ren,
    output sp_pkg::row_t bank_raddr,
    input sp_pkg::data_t bank_rdata,
    output logic dreq,
    output logic dwe,
    output sp_pkg::dram_addr_t daddr,
    output sp_pkg::data_t dwdata,
    input logic dack,
    input sp_pkg::data_t drdata,
    output logic greq,
    output sp_pkg::data_t gdata,
    output sp_pkg::row_t grow,
    input logic gack,
    output logic load_done,
    output logic store_done,
    output logic gemm_done
);
    import sp_pkg::*;

    bank_state_e state, next_state;
    opcode_e head_op;
    bank_t head_bank;
    row_t row_q;
    cnt_t cnt_q;
    dram_addr_t addr_q;

    assign head_op = opcode_e'(instr_head[OPC_LSB +: OPC_W]);
    assign head_bank = instr_head[BANK_LSB +: BANK_W];

    // Only the addressed bank claims the head
    assign take = (state == IDLE) && head_valid && (head_bank == bank_t'(BANK_NUM))
        && (head_op != OP_NOP);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            row_q <= '0;
            cnt_q <= '0;
            addr_q <= '0;
        end else begin
            state <= next_state;
            if (take) begin
                row_q <= instr_head[ROW_LSB +: ROW_W];
                cnt_q <= instr_head[CNT_LSB +: CNT_W];
                addr_q <= instr_head[ADDR_LSB +: DRAM_ADDR_W];
            end else if ((state == GM_WAIT) && !gack && (cnt_q != '0)) begin
                // Step to the next GEMM row
                row_q <= row_q + 1'b1;
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (take) begin
                    case (head_op)
                        OP_LOAD: next_state = LD_REQ;
                        OP_STORE: next_state = ST_READ;
                        OP_GEMM: next_state = GM_READ;
                        default: next_state = IDLE;
                    endcase
                end
            end
            LD_REQ: if (dack) next_state = LD_WAIT;
            LD_WAIT: if (!dack) next_state = IDLE;
            ST_READ: next_state = ST_REQ;
            ST_REQ: if (dack) next_state = ST_WAIT;
            ST_WAIT: if (!dack) next_state = IDLE;
            GM_READ: next_state = GM_REQ;
            GM_REQ: if (gack) next_state = GM_WAIT;
            GM_WAIT: begin
                if (!gack) begin
                    next_state = (cnt_q == '0) ? IDLE : GM_READ;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // LOAD writes the row while ack is high
    assign bank_wen = (state == LD_REQ) && dack;
    assign bank_waddr = row_q;
    assign bank_wdata = drdata;
    assign bank_ren = (state == ST_READ) || (state == GM_READ);
    assign bank_raddr = row_q;

    assign dreq = (state == LD_REQ) || (state == ST_REQ);
    assign dwe = (state == ST_REQ);
    assign daddr = addr_q;
    assign dwdata = bank_rdata;

    assign greq = (state == GM_REQ);
    assign gdata = bank_rdata;
    assign grow = row_q;

    assign load_done = (state == LD_WAIT) && !dack;
    assign store_done = (state == ST_WAIT) && !dack;
    assign gemm_done = (state == GM_WAIT) && !gack && (cnt_q == '0);

endmodule

// File: design/dram_arbiter.sv
module dram_arbiter (
    input logic CLK,
    input logic nRST,
    input logic [sp_pkg::NUM_BANKS-1:0] req_in,
    input logic [sp_pkg::NUM_BANKS-1:0] we_in,
    input sp_pkg::dram_addr_t [sp_pkg::NUM_BANKS-1:0] addr_in,
    input sp_pkg::data_t [sp_pkg::NUM_BANKS-1:0] wdata_in,
    output logic [sp_pkg::NUM_BANKS-1:0] ack_out,
    output sp_pkg::data_t [sp_pkg::NUM_BANKS-1:0] rdata_out,
    output logic dram_req,
    output logic dram_we,
    output sp_pkg::dram_addr_t dram_addr,
    output sp_pkg::data_t dram_wdata,
    input logic dram_ack,
    input sp_pkg::data_t dram_rdata
);
    import sp_pkg::*;

    bank_t grant;
    logic busy;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= 1'b0;
            grant <= '0;
        end else if (!busy) begin
            // Port is idle here since req is gated by busy
            if ((|req_in) && !dram_ack) begin
                busy <= 1'b1;
                grant <= lowest_req(req_in);
            end
        end else if (!req_in[grant] && !dram_ack) begin
            // Both phases returned low
            busy <= 1'b0;
        end
    end

    assign dram_req = busy && req_in[grant];
    assign dram_we = we_in[grant];
    assign dram_addr = addr_in[grant];
    assign dram_wdata = wdata_in[grant];

    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            ack_out[i] = busy && (grant == bank_t'(i)) && dram_ack;
            rdata_out[i] = dram_rdata;
        end
    end

endmodule

// File: design/gemm_feed.sv
module gemm_feed (
    input logic CLK,
    input logic nRST,
    input logic [sp_pkg::NUM_BANKS-1:0] greq,
    input sp_pkg::data_t [sp_pkg::NUM_BANKS-1:0] gdata,
    input sp_pkg::row_t [sp_pkg::NUM_BANKS-1:0] grow,
    output logic [sp_pkg::NUM_BANKS-1:0] gack,
    output logic array_valid,
    output sp_pkg::data_t array_data,
    output sp_pkg::row_t array_row_sel,
    input logic array_ready
);
    import sp_pkg::*;

    bank_t grant, next_grant;
    logic acking;
    logic can_load;
    logic load;

    // Register free, or its row is taken this cycle
    assign can_load = !array_valid || array_ready;
    assign load = !acking && can_load && (|greq);
    assign next_grant = lowest_req(greq);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            array_valid <= 1'b0;
            acking <= 1'b0;
            grant <= '0;
        end else if (load) begin
            array_valid <= 1'b1;
            acking <= 1'b1;
            grant <= next_grant;
        end else begin
            if (array_ready) begin
                array_valid <= 1'b0;
            end
            // Release after the bank drops its request
            if (acking && !greq[grant]) begin
                acking <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (load) begin
            array_data <= gdata[next_grant];
            array_row_sel <= grow[next_grant];
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_BANKS; i++) begin
            gack[i] = acking && (grant == bank_t'(i));
        end
    end

endmodule

// File: design/scratchpad.sv
module scratchpad #(
    parameter int FIFO_DEPTH = 4
) (
    input logic CLK,
    input logic nRST,
    input logic instr_wen,
    input sp_pkg::instr_t instr_wdata,
    output logic instr_full,
    output logic dram_req,
    output logic dram_we,
    output sp_pkg::dram_addr_t dram_addr,
    output sp_pkg::data_t dram_wdata,
    input logic dram_ack,
    input sp_pkg::data_t dram_rdata,
    output logic array_valid,
    output sp_pkg::data_t array_data,
    output sp_pkg::row_t array_row_sel,
    input logic array_ready,
    output logic load_complete,
    output logic store_complete,
    output logic gemm_complete
);
    import sp_pkg::*;

    instr_t instr_head;
    logic fifo_empty, head_valid, head_is_nop, fifo_ren;

    logic [NUM_BANKS-1:0] take;
    logic [NUM_BANKS-1:0] bank_wen, bank_ren;
    row_t [NUM_BANKS-1:0] bank_waddr, bank_raddr;
    data_t [NUM_BANKS-1:0] bank_wdata, bank_rdata;

    logic [NUM_BANKS-1:0] dreq, dwe, dack;
    dram_addr_t [NUM_BANKS-1:0] daddr;
    data_t [NUM_BANKS-1:0] dwdata, drdata;

    logic [NUM_BANKS-1:0] greq, gack;
    data_t [NUM_BANKS-1:0] gdata;
    row_t [NUM_BANKS-1:0] grow;

    logic [NUM_BANKS-1:0] load_done, store_done, gemm_done;

    sync_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) instr_fifo (
        .CLK(CLK),
        .nRST(nRST),
        .wen(instr_wen),
        .wdata(instr_wdata),
        .ren(fifo_ren),
        .rdata(instr_head),
        .full(instr_full),
        .empty(fifo_empty)
    );

    assign head_valid = !fifo_empty;
    // NOPs are popped without a taker
    assign head_is_nop = head_valid && (opcode_e'(instr_head[OPC_LSB +: OPC_W]) == OP_NOP);
    assign fifo_ren = (|take) || head_is_nop;

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        sp_bank bank_inst (
            .CLK(CLK),
            .nRST(nRST),
            .wen(bank_wen[b]),
            .waddr(bank_waddr[b]),
            .wdata(bank_wdata[b]),
            .ren(bank_ren[b]),
            .raddr(bank_raddr[b]),
            .rdata(bank_rdata[b])
        );

        bank_access_fsm #(.BANK_NUM(b)) fsm_inst (
            .CLK(CLK),
            .nRST(nRST),
            .instr_head(instr_head),
            .head_valid(head_valid),
            .take(take[b]),
            .bank_wen(bank_wen[b]),
            .bank_waddr(bank_waddr[b]),
            .bank_wdata(bank_wdata[b]),
            .bank_ren(bank_ren[b]),
            .bank_raddr(bank_raddr[b]),
            .bank_rdata(bank_rdata[b]),
            .dreq(dreq[b]),
            .dwe(dwe[b]),
            .daddr(daddr[b]),
            .dwdata(dwdata[b]),
            .dack(dack[b]),
            .drdata(drdata[b]),
            .greq(greq[b]),
            .gdata(gdata[b]),
            .grow(grow[b]),
            .gack(gack[b]),
            .load_done(load_done[b]),
            .store_done(store_done[b]),
            .gemm_done(gemm_done[b])
        );
    end

    dram_arbiter dram_arb (
        .CLK(CLK),
        .nRST(nRST),
        .req_in(dreq),
        .we_in(dwe),
        .addr_in(daddr),
        .wdata_in(dwdata),
        .ack_out(dack),
        .rdata_out(drdata),
        .dram_req(dram_req),
        .dram_we(dram_we),
        .dram_addr(dram_addr),
        .dram_wdata(dram_wdata),
        .dram_ack(dram_ack),
        .dram_rdata(dram_rdata)
    );

    gemm_feed feed (
        .CLK(CLK),
        .nRST(nRST),
        .greq(greq),
        .gdata(gdata),
        .grow(grow),
        .gack(gack),
        .array_valid(array_valid),
        .array_data(array_data),
        .array_row_sel(array_row_sel),
        .array_ready(array_ready)
    );

    assign load_complete = |load_done;
    assign store_complete = |store_done;
    assign gemm_complete = |gemm_done;

endmodule

// File: verification/dram_model.sv
module dram_model (
    input logic CLK,
    input logic nRST,
    input logic stall,
    input logic req,
    input logic we,
    input sp_pkg::dram_addr_t addr,
    input sp_pkg::data_t wdata,
    output logic ack,
    output sp_pkg::data_t rdata
);
    import sp_pkg::*;

    // Whole DRAM space that the testbench fills before reset ends
    data_t mem [1 << DRAM_ADDR_W];
    int unsigned write_count;
    int delay;
    logic waiting;

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ack <= 1'b0;
            rdata <= '0;
            waiting <= 1'b0;
            delay <= 0;
            write_count <= 0;
        end else if (!ack) begin
            if (req && !waiting) begin
                // New request picks how long to hold off the ack
                waiting <= 1'b1;
                delay <= $urandom_range(5, 0);
            end else if (req && waiting && !stall) begin
                if (delay == 0) begin
                    ack <= 1'b1;
                    waiting <= 1'b0;
                    // Random hold of the ack once req falls
                    delay <= $urandom_range(3, 0);
                    if (we) begin
                        mem[addr] = wdata;
                        write_count <= write_count + 1;
                    end else begin
                        rdata <= mem[addr];
                    end
                end else begin
                    delay <= delay - 1;
                end
            end
        end else if (!req) begin
            // Second half of the handshake
            if (delay == 0) begin
                ack <= 1'b0;
            end else begin
                delay <= delay - 1;
            end
        end
    end

endmodule

// File: verification/scratchpad_tb.sv
module scratchpad_tb;
    import sp_pkg::*;

    localparam int FIFO_DEPTH = 4;
    localparam int SEND_TIMEOUT = 2000;
    localparam int DRAIN_TIMEOUT = 20000;
    localparam int FULL_TIMEOUT = 200;

    logic CLK = 1'b0;
    logic nRST;
    logic instr_wen;
    instr_t instr_wdata;
    logic instr_full;
    logic dram_req, dram_we, dram_ack;
    dram_addr_t dram_addr;
    data_t dram_wdata, dram_rdata;
    logic array_valid;
    logic array_ready = 1'b0;
    data_t array_data;
    row_t array_row_sel;
    logic load_complete, store_complete, gemm_complete;
    logic dram_stall;

    // Source DRAM address of every bank row
    dram_addr_t src_addr [NUM_BANKS][BANK_ROWS];
    data_t exp_data [$];
    row_t exp_row [$];
    int loads_issued = 0;
    int stores_issued = 0;
    int gemms_issued = 0;
    int loads_done = 0;
    int stores_done = 0;
    int gemms_done = 0;

    logic prev_req = 1'b0;
    dram_addr_t prev_addr = '0;
    logic held = 1'b0;
    data_t held_data = '0;
    row_t held_row = '0;

    scratchpad #(.FIFO_DEPTH(FIFO_DEPTH)) scratchpad_inst (
        .CLK(CLK),
        .nRST(nRST),
        .instr_wen(instr_wen),
        .instr_wdata(instr_wdata),
        .instr_full(instr_full),
        .dram_req(dram_req),
        .dram_we(dram_we),
        .dram_addr(dram_addr),
        .dram_wdata(dram_wdata),
        .dram_ack(dram_ack),
        .dram_rdata(dram_rdata),
        .array_valid(array_valid),
        .array_data(array_data),
        .array_row_sel(array_row_sel),
        .array_ready(array_ready),
        .load_complete(load_complete),
        .store_complete(store_complete),
        .gemm_complete(gemm_complete)
    );

    dram_model dram_model_inst (
        .CLK(CLK),
        .nRST(nRST),
        .stall(dram_stall),
        .req(dram_req),
        .we(dram_we),
        .addr(dram_addr),
        .wdata(dram_wdata),
        .ack(dram_ack),
        .rdata(dram_rdata)
    );

    always #2 CLK = ~CLK;

    // Array accepts about three rows in four
    always @(posedge CLK) begin
        array_ready <= ($urandom_range(3, 0) != 0);
    end

    function automatic data_t dram_init(input dram_addr_t a);
        return 32'(32'(a) * 32'h9E3779B1 + 32'd1);
    endfunction

    function automatic instr_t pack_instr(input opcode_e op, input bank_t b, input row_t r,
            input cnt_t c, input dram_addr_t a);
        instr_t w;
        w = '0;
        w[OPC_LSB +: OPC_W] = op;
        w[BANK_LSB +: BANK_W] = b;
        w[ROW_LSB +: ROW_W] = r;
        w[CNT_LSB +: CNT_W] = c;
        w[ADDR_LSB +: DRAM_ADDR_W] = a;
        return w;
    endfunction

    function automatic dram_addr_t rand_load_addr();
        // Loads stay below 0x8000 and stores go above
        return dram_addr_t'($urandom_range(16'h7fff, 0));
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        report_failure($sformatf("Mismatch at time %0t: %s expected %h, got %h",
            $time, name, expected, actual));
    endtask

    task automatic send_instr(input instr_t w);
        int t;
        t = 0;
        @(negedge CLK);
        while (instr_full) begin
            t++;
            if (t > SEND_TIMEOUT) begin
                report_failure("Timeout waiting for room in the instruction FIFO");
            end
            @(negedge CLK);
        end
        @(posedge CLK);
        instr_wen <= 1'b1;
        instr_wdata <= w;
        @(posedge CLK);
        instr_wen <= 1'b0;
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (loads_done != loads_issued || stores_done != stores_issued
                || gemms_done != gemms_issued || exp_data.size() != 0) begin
            t++;
            if (t > DRAIN_TIMEOUT) begin
                report_failure("Timeout waiting for outstanding instructions to complete");
            end
            @(negedge CLK);
        end
    endtask

    task automatic load_row(input bank_t b, input row_t r, input dram_addr_t a);
        src_addr[b][r] = a;
        send_instr(pack_instr(OP_LOAD, b, r, '0, a));
        loads_issued++;
    endtask

    task automatic store_row(input bank_t b, input row_t r, input dram_addr_t dst);
        send_instr(pack_instr(OP_STORE, b, r, '0, dst));
        stores_issued++;
        drain();
        assert (dram_model_inst.mem[dst] == dram_init(src_addr[b][r])) else
            report_mismatch("dram write data", dram_init(src_addr[b][r]),
                dram_model_inst.mem[dst]);
    endtask

    task automatic gemm_rows(input bank_t b, input row_t r, input cnt_t c);
        row_t rr;
        for (int i = 0; i <= int'(c); i++) begin
            rr = row_t'(int'(r) + i);
            exp_row.push_back(rr);
            exp_data.push_back(dram_init(src_addr[b][rr]));
        end
        send_instr(pack_instr(OP_GEMM, b, r, c, '0));
        gemms_issued++;
    endtask

    task automatic wait_fifo_full();
        int t;
        t = 0;
        @(negedge CLK);
        while (!instr_full) begin
            t++;
            if (t > FULL_TIMEOUT) begin
                report_failure("instr_full did not rise with the DRAM stalled");
            end
            @(negedge CLK);
        end
    endtask

    // Completion counting, DRAM handshake and array feed checks
    always @(negedge CLK) begin
        if (nRST) begin
            if (load_complete) loads_done++;
            if (store_complete) stores_done++;
            if (gemm_complete) gemms_done++;
            if (dram_req && !prev_req) begin
                assert (!dram_ack) else
                    report_failure("dram_req rose while dram_ack was still high");
            end
            if (dram_req && prev_req) begin
                assert (dram_addr == prev_addr) else
                    report_mismatch("dram_addr", prev_addr, dram_addr);
            end
            if (held) begin
                assert (array_valid) else
                    report_failure("array_valid dropped before the row was accepted");
                assert (array_data == held_data) else
                    report_mismatch("array_data", held_data, array_data);
                assert (array_row_sel == held_row) else
                    report_mismatch("array_row_sel", held_row, array_row_sel);
            end
            if (array_valid && array_ready) begin
                assert (exp_data.size() > 0) else
                    report_failure("Unexpected row on the array feed");
                assert (array_row_sel == exp_row[0]) else
                    report_mismatch("array_row_sel", exp_row[0], array_row_sel);
                assert (array_data == exp_data[0]) else
                    report_mismatch("array_data", exp_data[0], array_data);
                void'(exp_row.pop_front());
                void'(exp_data.pop_front());
            end
            held = array_valid && !array_ready;
            held_data = array_data;
            held_row = array_row_sel;
            prev_req = dram_req;
            prev_addr = dram_addr;
        end
    end

    initial begin
        row_t r0;
        cnt_t c0;
        void'($urandom(32'h350a5e5f));
        nRST = 1'b0;
        instr_wen = 1'b0;
        instr_wdata = '0;
        dram_stall = 1'b0;
        for (int i = 0; i < (1 << DRAM_ADDR_W); i++) begin
            dram_model_inst.mem[i] = dram_init(dram_addr_t'(i));
        end
        repeat (10) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        assert (!dram_req && !array_valid && !instr_full && !load_complete
                && !store_complete && !gemm_complete) else
            report_failure("Outputs were not low after reset");

        // Fill every row with the banks interleaved
        for (int r = 0; r < BANK_ROWS; r++) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                load_row(bank_t'(b), row_t'(r), rand_load_addr());
            end
        end
        drain();
        for (int b = 0; b < NUM_BANKS; b++) begin
            for (int r = 0; r < BANK_ROWS; r++) begin
                store_row(bank_t'(b), row_t'(r), dram_addr_t'(16'h8000 + b * BANK_ROWS + r));
            end
        end

        // Random window per bank
        for (int b = 0; b < NUM_BANKS; b++) begin
            r0 = row_t'($urandom_range(BANK_ROWS - 1, 0));
            c0 = cnt_t'($urandom_range(BANK_ROWS - 1 - int'(r0), 0));
            gemm_rows(bank_t'(b), r0, c0);
            drain();
        end

        // GEMM on bank 2 while banks 0 and 1 load and bank 3 stores
        gemm_rows(2'd2, '0, 4'd15);
        // A NOP in the stream is popped and dropped
        send_instr(pack_instr(OP_NOP, 2'd0, '0, '0, '0));
        for (int i = 0; i < 8; i++) begin
            load_row(2'd0, row_t'(i), rand_load_addr());
            load_row(2'd1, row_t'(i + 8), rand_load_addr());
        end
        store_row(2'd3, 4'd5, 16'h9000);

        // Bank 0 stalls on a load while the rest pile up
        @(posedge CLK);
        dram_stall <= 1'b1;
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            load_row(2'd0, row_t'(i), rand_load_addr());
        end
        wait_fifo_full();
        @(posedge CLK);
        dram_stall <= 1'b0;
        drain();

        // Final contents of every bank
        for (int b = 0; b < NUM_BANKS; b++) begin
            gemm_rows(bank_t'(b), '0, 4'd15);
            drain();
        end
        assert (int'(dram_model_inst.write_count) == stores_issued) else
            report_mismatch("dram write count", stores_issued, dram_model_inst.write_count);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: files.f
design/sp_pkg.sv
design/sync_fifo.sv
design/sp_bank.sv
design/bank_access_fsm.sv
design/dram_arbiter.sv
design/gemm_feed.sv
design/scratchpad.sv
verification/dram_model.sv
verification/scratchpad_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the scratchpad testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module scratchpad_tb -f files.f \
    && ./obj_dir/Vscratchpad_tb > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "Simulation did not pass"; exit 1; }
echo "Simulation passed"
